/* src/cpu_pkg.sv */
// ====================
// Core definitions: opcodes, FSM states and the instruction word
// ====================

package cpu_pkg;

    // ====================
    // Instruction word geometry
    // ====================

    localparam int INSTR_W   = 16;
    localparam int OPCODE_W  = 4;
    localparam int OPERAND_W = 8;
    localparam int RSVD_W    = INSTR_W - OPCODE_W - OPERAND_W;

    // Accumulator instruction set
    typedef enum logic [OPCODE_W-1:0] {
        LDI   = 4'h0,
        LOAD  = 4'h1,
        STORE = 4'h2,
        ADD   = 4'h3,
        SUB   = 4'h4,
        SHL   = 4'h5,
        JMP   = 4'h6,
        JZ    = 4'h7,
        HALT  = 4'h8
    } opcode_e;

    // ====================
    // Core FSM
    // ====================

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        MEM_ACCESS,
        EXECUTE,
        HALTED
    } core_state_e;

    // Operand is a data address or an 8-bit immediate
    typedef struct packed {
        opcode_e                opcode;
        logic [RSVD_W-1:0]      reserved;
        logic [OPERAND_W-1:0]   operand;
    } instr_t;

endpackage

/* src/soc_pkg.sv */
// ====================
// System definitions: memory map, bus and board output types
// ====================

package soc_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int RAM_WORDS = 240;

    // ====================
    // Memory map
    // ====================

    // 0x00 to 0xEF is RAM, everything above is I/O
    localparam logic [ADDR_W-1:0] ADDR_LED    = 8'hF0;
    localparam logic [ADDR_W-1:0] ADDR_DIGIT  = 8'hF1;
    localparam logic [ADDR_W-1:0] ADDR_RESULT = 8'hF2;

    // Request side of the core bus
    typedef struct packed {
        logic               req;
        logic               we;
        logic [ADDR_W-1:0]  addr;
        logic [WORD_W-1:0]  wdata;
    } bus_req_t;

    // ack is a single-cycle pulse, rdata valid with it
    typedef struct packed {
        logic               ack;
        logic [WORD_W-1:0]  rdata;
    } bus_rsp_t;

    // Program load port, one word per cycle
    typedef struct packed {
        logic               en;
        logic [ADDR_W-1:0]  addr;
        logic [WORD_W-1:0]  data;
    } boot_write_t;

    // Segment bits, 1 means lit
    typedef struct packed {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
    } seg_t;

endpackage

/* src/cpu_core.sv */
// ====================
// 16-bit accumulator core
// Fetch, decode, data access and execute over a req/ack bus
// ====================

`timescale 1ns/1ps

module cpu_core
    import cpu_pkg::*, soc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    output bus_req_t    bus_req,
    input  bus_rsp_t    bus_rsp,
    output logic        halted
);

    core_state_e            state;
    logic [ADDR_W-1:0]      pc;
    logic [WORD_W-1:0]      acc;
    instr_t                 ir;
    logic [WORD_W-1:0]      mdr;

    logic                   is_mem_op;

    // Opcodes that need a data access after decode
    assign is_mem_op = (ir.opcode == LOAD) || (ir.opcode == STORE) ||
                       (ir.opcode == ADD)  || (ir.opcode == SUB);

    // ====================
    // Bus request
    // ====================

    // Fields come from registers only, so they hold while waiting for ack
    always_comb begin
        bus_req.req   = (state == FETCH) || (state == MEM_ACCESS);
        bus_req.we    = (state == MEM_ACCESS) && (ir.opcode == STORE);
        bus_req.addr  = (state == FETCH) ? pc : ir.operand;
        bus_req.wdata = acc;
    end

    assign halted = (state == HALTED);

    // ====================
    // Control FSM
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= FETCH;
                    end
                end

                FETCH: begin
                    if (bus_rsp.ack) begin
                        pc    <= pc + 1'b1;
                        state <= DECODE;
                    end
                end

                DECODE: begin
                    // Non-memory opcodes complete here
                    state <= FETCH;
                    case (ir.opcode)
                        LDI: begin
                            acc <= {{(WORD_W-OPERAND_W){1'b0}}, ir.operand};
                        end
                        SHL: begin
                            acc <= {acc[WORD_W-2:0], 1'b0};
                        end
                        JMP: begin
                            pc <= ir.operand;
                        end
                        JZ: begin
                            if (acc == '0) begin
                                pc <= ir.operand;
                            end
                        end
                        HALT: begin
                            state <= HALTED;
                        end
                        default: begin
                            if (is_mem_op) begin
                                state <= MEM_ACCESS;
                            end
                        end
                    endcase
                end

                MEM_ACCESS: begin
                    if (bus_rsp.ack) begin
                        state <= (ir.opcode == STORE) ? FETCH : EXECUTE;
                    end
                end

                EXECUTE: begin
                    // Write back the loaded operand
                    case (ir.opcode)
                        LOAD:    acc <= mdr;
                        ADD:     acc <= acc + mdr;
                        SUB:     acc <= acc - mdr;
                        default: acc <= acc;
                    endcase
                    state <= FETCH;
                end

                HALTED: begin
                    state <= HALTED;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Instruction and data capture
    always_ff @(posedge clk) begin
        if ((state == FETCH) && bus_rsp.ack) begin
            ir <= instr_t'(bus_rsp.rdata);
        end
        if ((state == MEM_ACCESS) && bus_rsp.ack) begin
            mdr <= bus_rsp.rdata;
        end
    end

    // ====================
    // Assertions
    // ====================

    // A pending request may not change until the slave acknowledges it
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        (bus_req.req && !bus_rsp.ack) |=> $stable(bus_req)
    ) else $error("bus request changed while waiting for ack");

endmodule

/* src/soc_memory.sv */
// ====================
// Program and data RAM with bus port and boot write port
// ====================

`timescale 1ns/1ps

module soc_memory
    import soc_pkg::*;
(
    input  logic        clk,
    input  bus_req_t    bus_req,
    output bus_rsp_t    bus_rsp,
    input  boot_write_t boot
);

    logic [WORD_W-1:0]  ram [0:RAM_WORDS-1];
    logic               ack;
    logic [WORD_W-1:0]  rdata;
    logic               bus_write;

    // One write per request, not repeated in the ack cycle
    assign bus_write = bus_req.req && bus_req.we && !ack;

    // Boot port has priority, it is only used while the core is idle
    always_ff @(posedge clk) begin
        if (boot.en) begin
            ram[boot.addr] <= boot.data;
        end else if (bus_write) begin
            ram[bus_req.addr] <= bus_req.wdata;
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        if (bus_req.req) begin
            rdata <= ram[bus_req.addr];
        end
    end

    // Pulse one cycle after req; clears itself while req is low in reset
    always_ff @(posedge clk) begin
        ack <= bus_req.req && !ack;
    end

    assign bus_rsp.ack   = ack;
    assign bus_rsp.rdata = rdata;

    // Loading a program while the core runs would corrupt it
    a_boot_idle: assert property (
        @(posedge clk) boot.en |-> !bus_req.req
    ) else $error("boot write during a bus request");

endmodule

/* src/bus_io_unit.sv */
// ====================
// Address decoder for RAM and board outputs
// ====================

`timescale 1ns/1ps

module bus_io_unit
    import soc_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  bus_req_t            core_req,
    output bus_rsp_t            core_rsp,
    output bus_req_t            mem_req,
    input  bus_rsp_t            mem_rsp,
    output logic                led_red,
    output logic                led_green,
    output seg_t                seg,
    output logic [WORD_W-1:0]   result
);

    logic               is_ram;
    logic               io_sel;
    logic               io_ack;
    logic [WORD_W-1:0]  io_rdata;
    logic [3:0]         digit;

    // Standard hex patterns, segments a to g
    function automatic seg_t hex_to_seg(input logic [3:0] v);
        case (v)
            4'h0: return seg_t'(7'b1111110);
            4'h1: return seg_t'(7'b0110000);
            4'h2: return seg_t'(7'b1101101);
            4'h3: return seg_t'(7'b1111001);
            4'h4: return seg_t'(7'b0110011);
            4'h5: return seg_t'(7'b1011011);
            4'h6: return seg_t'(7'b1011111);
            4'h7: return seg_t'(7'b1110000);
            4'h8: return seg_t'(7'b1111111);
            4'h9: return seg_t'(7'b1111011);
            4'hA: return seg_t'(7'b1110111);
            4'hB: return seg_t'(7'b0011111);
            4'hC: return seg_t'(7'b1001110);
            4'hD: return seg_t'(7'b0111101);
            4'hE: return seg_t'(7'b1001111);
            default: return seg_t'(7'b1000111);
        endcase
    endfunction

    // ====================
    // Decode
    // ====================

    assign is_ram = core_req.addr < ADDR_W'(RAM_WORDS);
    assign io_sel = core_req.req && !is_ram && !io_ack;

    always_comb begin
        mem_req     = core_req;
        mem_req.req = core_req.req && is_ram;
    end

    assign core_rsp.ack   = mem_rsp.ack || io_ack;
    assign core_rsp.rdata = io_ack ? io_rdata : mem_rsp.rdata;

    // ====================
    // I/O registers
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            io_ack    <= 1'b0;
            led_red   <= 1'b0;
            led_green <= 1'b0;
            digit     <= '0;
            seg       <= '0;
            result    <= '0;
        end else begin
            io_ack <= io_sel;
            if (io_sel && core_req.we) begin
                case (core_req.addr)
                    ADDR_LED: begin
                        led_red   <= core_req.wdata[0];
                        led_green <= core_req.wdata[1];
                    end
                    ADDR_DIGIT: begin
                        digit <= core_req.wdata[3:0];
                        seg   <= hex_to_seg(core_req.wdata[3:0]);
                    end
                    ADDR_RESULT: result <= core_req.wdata;
                    default:     result <= result;
                endcase
            end
        end
    end

    // Registered read, unmapped I/O reads as zero
    always_ff @(posedge clk) begin
        if (io_sel) begin
            case (core_req.addr)
                ADDR_LED:    io_rdata <= {{(WORD_W-2){1'b0}}, led_green, led_red};
                ADDR_DIGIT:  io_rdata <= {{(WORD_W-4){1'b0}}, digit};
                ADDR_RESULT: io_rdata <= result;
                default:     io_rdata <= '0;
            endcase
        end
    end

endmodule

/* src/soc_top.sv */
// ====================
// Microcontroller top: core, I/O decoder and RAM
// ====================

`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  boot_write_t         boot,
    output logic                led_red,
    output logic                led_green,
    output seg_t                seg,
    output logic [WORD_W-1:0]   result,
    output logic                halted
);

    bus_req_t   core_req;
    bus_rsp_t   core_rsp;
    bus_req_t   mem_req;
    bus_rsp_t   mem_rsp;

    cpu_core u_core (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .bus_req (core_req),
        .bus_rsp (core_rsp),
        .halted  (halted)
    );

    // Splits core traffic between RAM and the board registers
    bus_io_unit u_io (
        .clk       (clk),
        .reset     (reset),
        .core_req  (core_req),
        .core_rsp  (core_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .led_red   (led_red),
        .led_green (led_green),
        .seg       (seg),
        .result    (result)
    );

    soc_memory u_mem (
        .clk     (clk),
        .bus_req (mem_req),
        .bus_rsp (mem_rsp),
        .boot    (boot)
    );

endmodule

/* tests/tb_clock.sv */
// ====================
// Testbench clock, 4 ns period
// ====================

`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

endmodule

/* tests/tb_asm.svh */
// ====================
// Instruction encoding and the test programs
// ====================

`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// Scratch words for the loop programs
localparam logic [7:0] CNT_ADDR = 8'hA0;
localparam logic [7:0] VAL_ADDR = 8'hA1;
localparam logic [7:0] ONE_ADDR = 8'hA2;

// Opcode, zero reserved field, operand
function automatic logic [15:0] encode(input opcode_e op, input logic [7:0] operand);
    return {op, 4'h0, operand};
endfunction

// Unused words get an address-dependent fill
task automatic clear_image();
    for (int a = 0; a < RAM_WORDS; a++) begin
        image[a] = {a[7:0] ^ 8'h5A, ~a[7:0]};
    end
endtask

// Doubles a value n times with n read from RAM
task automatic build_doubler(input logic [7:0] n);
    clear_image();
    image[CNT_ADDR] = {8'h00, n};
    image[ONE_ADDR] = 16'h0001;
    image[0]  = encode(LDI, 8'd1);
    image[1]  = encode(STORE, VAL_ADDR);
    image[2]  = encode(LOAD, CNT_ADDR);
    image[3]  = encode(JZ, 8'd10);
    image[4]  = encode(SUB, ONE_ADDR);
    image[5]  = encode(STORE, CNT_ADDR);
    image[6]  = encode(LOAD, VAL_ADDR);
    image[7]  = encode(SHL, 8'd0);
    image[8]  = encode(STORE, VAL_ADDR);
    image[9]  = encode(JMP, 8'd2);
    image[10] = encode(LOAD, VAL_ADDR);
    image[11] = encode(STORE, ADDR_RESULT);
    image[12] = encode(HALT, 8'd0);
endtask

// Random LDI, ADD, SUB and STORE/LOAD pairs over random data words
task automatic build_arith();
    int          pc;
    logic [15:0] r;
    logic [7:0]  addr;
    clear_image();
    for (int a = 128; a < 192; a++) begin
        image[a] = rand_bits(16);
    end
    r = rand_bits(8);
    image[0] = encode(LDI, r[7:0]);
    pc = 1;
    repeat (12) begin
        r    = rand_bits(6);
        addr = {2'b10, r[5:0]};
        r    = rand_bits(10);
        case (r[9:8])
            2'd0: image[pc] = encode(LDI, r[7:0]);
            2'd1: image[pc] = encode(ADD, addr);
            2'd2: image[pc] = encode(SUB, addr);
            default: begin
                image[pc] = encode(STORE, addr);
                pc++;
                image[pc] = encode(LOAD, addr);
            end
        endcase
        pc++;
    end
    image[pc]     = encode(STORE, ADDR_RESULT);
    image[pc + 1] = encode(HALT, 8'd0);
endtask

// Digit write followed by digit and result readback
task automatic build_digit(input logic [7:0] value);
    clear_image();
    image[0] = encode(LDI, value);
    image[1] = encode(STORE, ADDR_DIGIT);
    image[2] = encode(LOAD, ADDR_DIGIT);
    image[3] = encode(STORE, ADDR_RESULT);
    image[4] = encode(ADD, ADDR_RESULT);
    image[5] = encode(STORE, ADDR_RESULT);
    image[6] = encode(HALT, 8'd0);
endtask

// Countdown from k with green inside the loop and red at the end
// The LED register is read back into result before halt
task automatic build_leds(input logic [7:0] k);
    clear_image();
    image[ONE_ADDR] = 16'h0001;
    image[0]  = encode(LDI, k);
    image[1]  = encode(STORE, CNT_ADDR);
    image[2]  = encode(LOAD, CNT_ADDR);
    image[3]  = encode(JZ, 8'd9);
    image[4]  = encode(SUB, ONE_ADDR);
    image[5]  = encode(STORE, CNT_ADDR);
    image[6]  = encode(LDI, 8'd2);
    image[7]  = encode(STORE, ADDR_LED);
    image[8]  = encode(JMP, 8'd2);
    image[9]  = encode(LDI, 8'd1);
    image[10] = encode(STORE, ADDR_LED);
    image[11] = encode(LOAD, ADDR_LED);
    image[12] = encode(STORE, ADDR_RESULT);
    image[13] = encode(HALT, 8'd0);
endtask

`endif

/* tests/tb_soc.sv */
// ====================
// Microcontroller testbench
// Random programs checked against an instruction-level model
// ====================

`timescale 1ns/1ps

module tb_soc
    import cpu_pkg::*, soc_pkg::*;
();

    localparam int WAIT_LIMIT  = 4000;
    localparam int MODEL_STEPS = 2000;
    localparam int ROUNDS      = 4;

    // Hex digit patterns, segment a in the top bit
    localparam logic [6:0] HEX_SEGS [0:15] = '{
        7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70,
        7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47
    };

    logic               clk;
    logic               reset;
    logic               start;
    boot_write_t        boot;
    logic               led_red;
    logic               led_green;
    seg_t               seg;
    logic [WORD_W-1:0]  result;
    logic               halted;

    logic [31:0]        lfsr;
    logic [WORD_W-1:0]  image [0:RAM_WORDS-1];
    logic [WORD_W-1:0]  model_mem [0:RAM_WORDS-1];
    logic [1:0]         exp_led;
    logic [3:0]         exp_digit;
    logic [6:0]         exp_seg;
    logic [WORD_W-1:0]  exp_result;
    int                 exp_rises;
    int                 green_rises;

    tb_clock u_clock (
        .clk (clk)
    );

    soc_top u_soc_top (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .boot      (boot),
        .led_red   (led_red),
        .led_green (led_green),
        .seg       (seg),
        .result    (result),
        .halted    (halted)
    );

    // ====================
    // Random numbers
    // ====================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] rand_bits(input int width);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // 1 to 15, zero folded onto 1
    function automatic logic [7:0] rand_count();
        logic [15:0] r;
        r = rand_bits(4);
        return (r[3:0] == 4'd0) ? 8'd1 : {4'h0, r[3:0]};
    endfunction

    `include "tb_asm.svh"

    // ====================
    // Reference model
    // ====================

    function automatic logic [15:0] model_read(input logic [7:0] addr);
        if (addr < ADDR_W'(RAM_WORDS)) return model_mem[addr];
        if (addr == ADDR_LED) return {14'h0, exp_led};
        if (addr == ADDR_DIGIT) return {12'h0, exp_digit};
        if (addr == ADDR_RESULT) return exp_result;
        return '0;
    endfunction

    task automatic model_write(input logic [7:0] addr, input logic [15:0] data);
        if (addr < ADDR_W'(RAM_WORDS)) begin
            model_mem[addr] = data;
        end else if (addr == ADDR_LED) begin
            if (data[1] && !exp_led[1]) exp_rises++;
            exp_led = data[1:0];
        end else if (addr == ADDR_DIGIT) begin
            exp_digit = data[3:0];
            exp_seg   = HEX_SEGS[data[3:0]];
        end else if (addr == ADDR_RESULT) begin
            exp_result = data;
        end
    endtask

    task automatic run_model();
        logic [WORD_W-1:0] acc;
        logic [ADDR_W-1:0] pc;
        logic [WORD_W-1:0] data;
        instr_t            ins;
        acc        = '0;
        pc         = '0;
        exp_led    = '0;
        exp_digit  = '0;
        exp_seg    = '0;
        exp_result = '0;
        exp_rises  = 0;
        for (int a = 0; a < RAM_WORDS; a++) begin
            model_mem[a] = image[a];
        end
        for (int step = 0; step < MODEL_STEPS; step++) begin
            ins  = instr_t'(model_read(pc));
            pc   = pc + 8'd1;
            data = model_read(ins.operand);
            case (ins.opcode)
                LDI:     acc = {8'h00, ins.operand};
                LOAD:    acc = data;
                STORE:   model_write(ins.operand, acc);
                ADD:     acc = acc + data;
                SUB:     acc = acc - data;
                SHL:     acc = acc << 1;
                JMP:     pc = ins.operand;
                JZ:      if (acc == '0) pc = ins.operand;
                HALT:    return;
                default: ;
            endcase
        end
        abort_run("Reference model never reached HALT");
    endtask

    // ====================
    // Checks and DUT control
    // ====================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        start = 1'b0;
        boot  = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic load_image();
        for (int a = 0; a < RAM_WORDS; a++) begin
            @(negedge clk);
            boot.en   = 1'b1;
            boot.addr = a[ADDR_W-1:0];
            boot.data = image[a];
        end
        @(negedge clk);
        boot = '0;
    endtask

    // Boot, start, wait for halt and compare every output with the model
    task automatic run_program(input string name);
        int   cycles;
        logic prev_green;
        apply_reset();
        load_image();
        run_model();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start       = 1'b0;
        prev_green  = led_green;
        green_rises = 0;
        cycles      = 0;
        while (halted !== 1'b1) begin
            @(negedge clk);
            if (led_green && !prev_green) green_rises++;
            prev_green = led_green;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run($sformatf("Timed out waiting for halted in the %s program", name));
            end
        end
        check_value("result", 32'(result), 32'(exp_result));
        check_value("led_red", 32'(led_red), 32'(exp_led[0]));
        check_value("led_green", 32'(led_green), 32'(exp_led[1]));
        check_value("seg", 32'(seg), 32'(exp_seg));
        check_value("led_green rises", 32'(green_rises), 32'(exp_rises));
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        logic [15:0] r;
        logic [7:0]  n;
        reset = 1'b1;
        start = 1'b0;
        boot  = '0;
        lfsr  = 32'h4b5f;
        apply_reset();

        // Outputs quiet until a program runs
        check_value("led_red", 32'(led_red), 32'd0);
        check_value("led_green", 32'(led_green), 32'd0);
        check_value("seg", 32'(seg), 32'd0);
        check_value("result", 32'(result), 32'd0);
        check_value("halted", 32'(halted), 32'd0);

        for (int round = 0; round < ROUNDS; round++) begin
            n = rand_count();
            build_doubler(n);
            run_program("doubler");
            check_value("result", 32'(result), 32'd1 << n);

            build_arith();
            run_program("arithmetic");

            r = rand_bits(8);
            build_digit(r[7:0]);
            run_program("digit");

            n = rand_count();
            build_leds(n);
            run_program("LED countdown");
            check_value("led_green rises", 32'(green_rises), 32'd1);
            check_value("led_red", 32'(led_red), 32'd1);
            check_value("led_green", 32'(led_green), 32'd0);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* build.f */
+incdir+tests
src/cpu_pkg.sv
src/soc_pkg.sv
src/cpu_core.sv
src/soc_memory.sv
src/bus_io_unit.sv
src/soc_top.sv
tests/tb_clock.sv
tests/tb_soc.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_soc \
    -o tb_soc_sim > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_soc_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
